//--- rtl/frontend_pkg.sv
// Fetch front end shared widths, address fields and predictor constants
`default_nettype none

package frontend_pkg;

  typedef logic [31:0] ip_t;        // byte address in the instruction stream
  typedef logic [7:0]  ght_t;       // newest outcome in bit 0
  typedef logic [3:0]  btb_index_t;
  typedef logic [23:0] btb_tag_t;
  typedef logic [7:0]  pht_index_t;
  typedef logic [1:0]  slot_pred_t; // one direction bit per slot

  localparam ip_t reset_ip     = 32'h0000_1000;
  localparam ip_t bundle_bytes = 32'd16;

  localparam int btb_entries = 16;  // per slot
  localparam int pht_entries = 256; // per table

  // update throttles on the mispredict counter
  localparam logic [7:0] throttle_a_mask = 8'h03;
  localparam logic [7:0] throttle_b_mask = 8'h0f;
  localparam logic [7:0] throttle_c_mask = 8'hff;

  // target buffer address split, bits 3:0 are the offset in the bundle
  function automatic btb_index_t btb_index_of(input ip_t ip);
    return ip[7:4];
  endfunction

  function automatic btb_tag_t btb_tag_of(input ip_t ip);
    return ip[31:8];
  endfunction

  // history after shifting in outcomes, newest in bit 0
  function automatic ght_t ght_push1(input ght_t ght, input logic taken);
    return {ght[6:0], taken};
  endfunction

  function automatic ght_t ght_push2(input ght_t ght, input logic [1:0] outcomes);
    return {ght[5:0], outcomes};
  endfunction

endpackage

`default_nettype wire

//--- rtl/fetch_sequencer.sv
// Fetch sequencer holding the instruction pointer and global history registers
`default_nettype none

module fetch_sequencer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [1:0]               slot_hit,
  input  frontend_pkg::ip_t        slot_target0,
  input  frontend_pkg::ip_t        slot_target1,
  input  frontend_pkg::slot_pred_t slot_pred,
  input  logic                     redirect,
  input  frontend_pkg::ip_t        redirect_ip,
  input  frontend_pkg::ght_t       redirect_ght,
  output frontend_pkg::ip_t        fetch_ip,
  output frontend_pkg::ght_t       fetch_ght
);

  import frontend_pkg::*;

  ip_t  seq_ip;
  ip_t  next_ip;
  ght_t next_ght;

  // single-hit case, whichever slot it is
  logic single_taken;
  ip_t  single_target;

  assign seq_ip        = fetch_ip + bundle_bytes;
  assign single_taken  = slot_hit[0] ? slot_pred[0] : slot_pred[1];
  assign single_target = slot_hit[0] ? slot_target0 : slot_target1;

  // next-pointer selection, slot 0 wins when both hit
  always_comb begin
    next_ip  = seq_ip;
    next_ght = fetch_ght; // no hit leaves history alone
    if (&slot_hit) begin
      if (slot_pred[0]) begin
        next_ip  = slot_target0;
        next_ght = ght_push1(fetch_ght, 1'b1);
      end else if (slot_pred[1]) begin
        next_ip  = slot_target1;
        next_ght = ght_push2(fetch_ght, 2'b01); // slot 0 not taken, then slot 1 taken
      end else begin
        next_ght = ght_push2(fetch_ght, 2'b00);
      end
    end else if (^slot_hit) begin
      if (single_taken) begin
        next_ip  = single_target;
        next_ght = ght_push1(fetch_ght, 1'b1);
      end else begin
        next_ght = ght_push1(fetch_ght, 1'b0);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip  <= reset_ip;
      fetch_ght <= '0;
    end else if (redirect) begin
      // retire repair overrides the prediction
      fetch_ip  <= redirect_ip;
      fetch_ght <= redirect_ght;
    end else begin
      fetch_ip  <= next_ip;
      fetch_ght <= next_ght;
    end
  end

endmodule

`default_nettype wire

//--- rtl/branch_target_buffer.sv
// Two-slot tagged branch target buffer with fetch lookup and retire install
`default_nettype none

module branch_target_buffer (
  input  logic              clk,
  input  logic              rst,
  input  frontend_pkg::ip_t fetch_ip,
  output logic [1:0]        slot_hit,
  output frontend_pkg::ip_t slot_target0,
  output frontend_pkg::ip_t slot_target1,
  input  logic              install,
  input  logic              install_slot,
  input  frontend_pkg::ip_t install_src_ip,
  input  frontend_pkg::ip_t install_target
);

  import frontend_pkg::*;

  // per entry, one valid bit for each slot
  logic [1:0] entry_valid  [btb_entries];
  btb_tag_t   entry_tag    [2][btb_entries];
  ip_t        entry_target [2][btb_entries];

  btb_index_t fetch_idx;
  btb_tag_t   fetch_tag;
  btb_index_t install_idx;

  assign fetch_idx   = btb_index_of(fetch_ip);
  assign fetch_tag   = btb_tag_of(fetch_ip);
  assign install_idx = btb_index_of(install_src_ip);

  // lookup
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      slot_hit[s] = entry_valid[fetch_idx][s] && (entry_tag[s][fetch_idx] == fetch_tag);
    end
  end

  assign slot_target0 = entry_target[0][fetch_idx];
  assign slot_target1 = entry_target[1][fetch_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < btb_entries; i++) begin
        entry_valid[i] <= '0;
      end
    end else if (install) begin
      entry_valid[install_idx][install_slot] <= 1'b1;
    end
  end

  // tag and target store
  always_ff @(posedge clk) begin
    if (install) begin
      entry_tag[install_slot][install_idx]    <= btb_tag_of(install_src_ip);
      entry_target[install_slot][install_idx] <= install_target;
    end
  end

endmodule

`default_nettype wire

//--- rtl/direction_predictor.sv
// Direction predictor from three XORed history tables with throttled updates
`default_nettype none

module direction_predictor (
  input  logic                     clk,
  input  logic                     rst,
  input  frontend_pkg::ip_t        fetch_ip,
  input  frontend_pkg::ght_t       fetch_ght,
  output frontend_pkg::slot_pred_t slot_pred,
  input  logic                     mispredict,
  input  logic                     upd_slot,
  input  frontend_pkg::ip_t        upd_ip,
  input  frontend_pkg::ght_t       upd_ght
);

  import frontend_pkg::*;

  // A leans on the pointer, C on the history
  function automatic pht_index_t index_a(input ip_t ip, input ght_t ght);
    return {ip[9:4], ght[1:0]};
  endfunction

  function automatic pht_index_t index_b(input ip_t ip, input ght_t ght);
    return {ip[7:4], ght[3:0]};
  endfunction

  function automatic pht_index_t index_c(input ip_t ip, input ght_t ght);
    return {ip[5:4], ght[5:0]};
  endfunction

  slot_pred_t tbl_a [pht_entries];
  slot_pred_t tbl_b [pht_entries];
  slot_pred_t tbl_c [pht_entries];

  logic [7:0] mispred_cnt;

  pht_index_t upd_idx_a;
  pht_index_t upd_idx_b;
  pht_index_t upd_idx_c;

  logic upd_a;
  logic upd_b;
  logic upd_c;

  assign slot_pred = tbl_a[index_a(fetch_ip, fetch_ght)]
                   ^ tbl_b[index_b(fetch_ip, fetch_ght)]
                   ^ tbl_c[index_c(fetch_ip, fetch_ght)];

  assign upd_idx_a = index_a(upd_ip, upd_ght);
  assign upd_idx_b = index_b(upd_ip, upd_ght);
  assign upd_idx_c = index_c(upd_ip, upd_ght);

  // counter value before this mispredict's increment
  assign upd_a = (mispred_cnt & throttle_a_mask) == throttle_a_mask;
  assign upd_b = (mispred_cnt & throttle_b_mask) == throttle_b_mask;
  assign upd_c = (mispred_cnt & throttle_c_mask) == throttle_c_mask;

  always_ff @(posedge clk) begin
    if (rst) begin
      mispred_cnt <= '0;
      for (int i = 0; i < pht_entries; i++) begin
        tbl_a[i] <= '0;
        tbl_b[i] <= '0;
        tbl_c[i] <= '0;
      end
    end else if (mispredict) begin
      mispred_cnt <= mispred_cnt + 8'd1;
      if (upd_a) tbl_a[upd_idx_a][upd_slot] <= ~tbl_a[upd_idx_a][upd_slot];
      if (upd_b) tbl_b[upd_idx_b][upd_slot] <= ~tbl_b[upd_idx_b][upd_slot];
      if (upd_c) tbl_c[upd_idx_c][upd_slot] <= ~tbl_c[upd_idx_c][upd_slot]; // every 256th
    end
  end

endmodule

`default_nettype wire

//--- rtl/frontend.sv
// Instruction fetch front end joining sequencer, target buffer and predictor
`default_nettype none

module frontend (
  input  logic               clk,
  input  logic               rst,
  input  logic               retire_valid,
  input  logic               retire_slot,
  input  frontend_pkg::ip_t  retire_src_ip,
  input  frontend_pkg::ip_t  retire_target,
  input  frontend_pkg::ght_t retire_ght,
  input  logic               retire_mispred,
  input  frontend_pkg::ip_t  retire_next_ip,
  output frontend_pkg::ip_t  fetch_ip,
  output frontend_pkg::ght_t fetch_ght
);

  import frontend_pkg::*;

  logic [1:0] slot_hit;
  ip_t        slot_target0;
  ip_t        slot_target1;
  slot_pred_t slot_pred;
  logic       retire_redirect; // mispredicting retire

  assign retire_redirect = retire_valid & retire_mispred;

  fetch_sequencer i_fetch_sequencer (
    .clk          (clk),
    .rst          (rst),
    .slot_hit     (slot_hit),
    .slot_target0 (slot_target0),
    .slot_target1 (slot_target1),
    .slot_pred    (slot_pred),
    .redirect     (retire_redirect),
    .redirect_ip  (retire_next_ip),
    .redirect_ght (retire_ght),
    .fetch_ip     (fetch_ip),
    .fetch_ght    (fetch_ght)
  );

  branch_target_buffer i_branch_target_buffer (
    .clk            (clk),
    .rst            (rst),
    .fetch_ip       (fetch_ip),
    .slot_hit       (slot_hit),
    .slot_target0   (slot_target0),
    .slot_target1   (slot_target1),
    .install        (retire_valid), // every retired branch installs
    .install_slot   (retire_slot),
    .install_src_ip (retire_src_ip),
    .install_target (retire_target)
  );

  direction_predictor i_direction_predictor (
    .clk        (clk),
    .rst        (rst),
    .fetch_ip   (fetch_ip),
    .fetch_ght  (fetch_ght),
    .slot_pred  (slot_pred),
    .mispredict (retire_redirect),
    .upd_slot   (retire_slot),
    .upd_ip     (retire_src_ip),
    .upd_ght    (retire_ght)
  );

endmodule

`default_nettype wire

//--- testbench/tb_frontend.sv
// Fetch front end testbench with a reference model, directed and random retire traffic
`default_nettype none

module tb_frontend;
  timeunit 1ns;
  timeprecision 100ps;

  import frontend_pkg::*;

  localparam int clk_period = 100;
  // reset walk, install, redirect, 256 mispredicts, slot priority, random traffic
  localparam int test_cycles = 16 + 16 + 8 + 256 * 4 + 40 + 320;
  localparam int watchdog_cycles = test_cycles + 200;

  logic clk;
  logic rst;
  logic retire_valid;
  logic retire_slot;
  ip_t  retire_src_ip;
  ip_t  retire_target;
  ght_t retire_ght;
  logic retire_mispred;
  ip_t  retire_next_ip;
  ip_t  fetch_ip;
  ght_t fetch_ght;

  int         errors = 0;
  int         test_errors;
  int         tests_passed = 0;
  int         tests_failed = 0;
  integer     seed;
  logic [7:0] mispred_count; // directed mispredicts, wraps like the DUT counter

  // reference model state
  logic       ref_valid  [2][btb_entries];
  btb_tag_t   ref_tag    [2][btb_entries];
  ip_t        ref_target [2][btb_entries];
  slot_pred_t ref_tbl_a  [pht_entries];
  slot_pred_t ref_tbl_b  [pht_entries];
  slot_pred_t ref_tbl_c  [pht_entries];
  logic [7:0] ref_cnt;
  ip_t        ref_ip;
  ght_t       ref_ght;

  frontend i_frontend (
    .clk            (clk),
    .rst            (rst),
    .retire_valid   (retire_valid),
    .retire_slot    (retire_slot),
    .retire_src_ip  (retire_src_ip),
    .retire_target  (retire_target),
    .retire_ght     (retire_ght),
    .retire_mispred (retire_mispred),
    .retire_next_ip (retire_next_ip),
    .fetch_ip       (fetch_ip),
    .fetch_ght      (fetch_ght)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    logic [3:0] fidx;
    logic [3:0] ridx;
    logic [1:0] hit;
    logic [1:0] pred;
    logic       s;
    ip_t        nxt_ip;
    ght_t       nxt_ght;
    if (rst) begin
      ref_ip  <= reset_ip;
      ref_ght <= '0;
      ref_cnt <= '0;
      for (int i = 0; i < btb_entries; i++) begin
        ref_valid[0][i] <= 1'b0;
        ref_valid[1][i] <= 1'b0;
      end
      for (int i = 0; i < pht_entries; i++) begin
        ref_tbl_a[i] <= '0;
        ref_tbl_b[i] <= '0;
        ref_tbl_c[i] <= '0;
      end
    end else begin
      fidx = ref_ip[7:4];
      ridx = retire_src_ip[7:4];
      for (int k = 0; k < 2; k++) begin
        hit[k] = ref_valid[k][fidx] && (ref_tag[k][fidx] == ref_ip[31:8]);
      end
      pred = ref_tbl_a[{ref_ip[9:4], ref_ght[1:0]}]
           ^ ref_tbl_b[{ref_ip[7:4], ref_ght[3:0]}]
           ^ ref_tbl_c[{ref_ip[5:4], ref_ght[5:0]}];
      nxt_ip  = ref_ip + bundle_bytes;
      nxt_ght = ref_ght;
      if (hit == 2'b11) begin
        if (pred[0]) begin
          nxt_ip  = ref_target[0][fidx];
          nxt_ght = {ref_ght[6:0], 1'b1};
        end else if (pred[1]) begin
          nxt_ip  = ref_target[1][fidx];
          nxt_ght = {ref_ght[5:0], 2'b01};
        end else begin
          nxt_ght = {ref_ght[5:0], 2'b00};
        end
      end else if (hit != 2'b00) begin
        s = hit[1];
        nxt_ght = {ref_ght[6:0], pred[s]};
        if (pred[s]) nxt_ip = ref_target[s][fidx];
      end
      if (retire_valid) begin
        ref_valid[retire_slot][ridx]  <= 1'b1;
        ref_tag[retire_slot][ridx]    <= retire_src_ip[31:8];
        ref_target[retire_slot][ridx] <= retire_target;
      end
      if (retire_valid && retire_mispred) begin
        ref_ip  <= retire_next_ip;
        ref_ght <= retire_ght;
        ref_cnt <= ref_cnt + 8'd1;
        if (ref_cnt[1:0] == 2'b11) begin
          ref_tbl_a[{retire_src_ip[9:4], retire_ght[1:0]}][retire_slot] <=
            ~ref_tbl_a[{retire_src_ip[9:4], retire_ght[1:0]}][retire_slot];
        end
        if (ref_cnt[3:0] == 4'hf) begin
          ref_tbl_b[{retire_src_ip[7:4], retire_ght[3:0]}][retire_slot] <=
            ~ref_tbl_b[{retire_src_ip[7:4], retire_ght[3:0]}][retire_slot];
        end
        if (ref_cnt == 8'hff) begin
          ref_tbl_c[{retire_src_ip[5:4], retire_ght[5:0]}][retire_slot] <=
            ~ref_tbl_c[{retire_src_ip[5:4], retire_ght[5:0]}][retire_slot];
        end
      end else begin
        ref_ip  <= nxt_ip;
        ref_ght <= nxt_ght;
      end
    end
  end

  fetch_ip_matches_model: assert property (@(posedge clk) disable iff (rst) fetch_ip == ref_ip)
    else begin
      $display("[FAIL] %0t ns: fetch_ip %h, model expects %h", $time,
               $sampled(fetch_ip), $sampled(ref_ip));
      errors++;
    end

  fetch_ght_matches_model: assert property (@(posedge clk) disable iff (rst) fetch_ght == ref_ght)
    else begin
      $display("[FAIL] %0t ns: fetch_ght %h, model expects %h", $time,
               $sampled(fetch_ght), $sampled(ref_ght));
      errors++;
    end

  task automatic expect_fetch(input ip_t exp_ip, input ght_t exp_ght, input string what);
    @(negedge clk);
    assert (fetch_ip === exp_ip && fetch_ght === exp_ght)
      else begin
        $display("[FAIL] %0t ns: %s: fetch_ip %h fetch_ght %h, expected %h %h",
                 $time, what, fetch_ip, fetch_ght, exp_ip, exp_ght);
        errors++;
      end
  endtask

  // one-cycle retire strobe
  task automatic retire_strobe(input logic slot, input ip_t src, input ip_t target,
                               input ght_t ght, input logic mispred, input ip_t next_ip);
    @(posedge clk);
    retire_valid   <= 1'b1;
    retire_slot    <= slot;
    retire_src_ip  <= src;
    retire_target  <= target;
    retire_ght     <= ght;
    retire_mispred <= mispred;
    retire_next_ip <= next_ip;
    @(posedge clk);
    retire_valid   <= 1'b0;
    retire_mispred <= 1'b0;
    if (mispred) mispred_count++;
  endtask

  // redirect back to the retired bundle, then check the fetch that follows
  task automatic mispredict_step(input logic slot, input ip_t src, input ip_t target,
                                 input ght_t ght, input ip_t exp_ip, input ght_t exp_ght);
    retire_strobe(slot, src, target, ght, 1'b1, src);
    expect_fetch(src, ght, "redirect to retired bundle");
    expect_fetch(exp_ip, exp_ght, "fetch after redirect");
  endtask

  task automatic random_retire_traffic(input int n_cycles);
    logic [31:0] r_ctl;
    logic [31:0] r_dst;
    logic [31:0] r_nxt;
    for (int n = 0; n < n_cycles; n++) begin
      @(posedge clk);
      r_ctl = $random(seed);
      r_dst = $random(seed);
      r_nxt = $random(seed);
      retire_valid   <= (r_ctl[1:0] == 2'b00);
      retire_slot    <= r_ctl[2];
      retire_mispred <= r_ctl[3];
      retire_src_ip  <= 32'h0000_a000 + {r_ctl[9:4], 4'h0}; // small pool, so entries hit
      retire_target  <= 32'h0000_a000 + {r_dst[9:4], 4'h0};
      retire_ght     <= r_dst[23:16];
      retire_next_ip <= 32'h0000_a000 + {r_nxt[9:4], 4'h0};
    end
    @(posedge clk);
    retire_valid <= 1'b0;
  endtask

  task automatic start_test();
    test_errors = errors;
  endtask

  task automatic report_test(input string name);
    if (errors == test_errors) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_errors);
    end
  endtask

  initial begin
    logic parity;
    clk            = 1'b0;
    rst            = 1'b1;
    retire_valid   = 1'b0;
    retire_slot    = 1'b0;
    retire_src_ip  = '0;
    retire_target  = '0;
    retire_ght     = '0;
    retire_mispred = 1'b0;
    retire_next_ip = '0;
    seed           = 32'h4f148842;
    mispred_count  = '0;

    start_test();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    expect_fetch(reset_ip, 8'h00, "pointer after reset");
    for (int k = 1; k <= 8; k++) begin
      expect_fetch(reset_ip + k * bundle_bytes, 8'h00, "sequential step");
    end
    report_test("reset and sequential fetch");

    start_test();
    retire_strobe(1'b0, 32'h0000_2040, 32'h0000_3000, 8'h00, 1'b0, 32'h0);
    retire_strobe(1'b1, 32'h0000_8000, 32'h0000_9000, 8'h5a, 1'b1, 32'h0000_2020);
    expect_fetch(32'h0000_2020, 8'h5a, "walk toward installed bundle");
    expect_fetch(32'h0000_2030, 8'h5a, "walk toward installed bundle");
    expect_fetch(32'h0000_2040, 8'h5a, "reach installed bundle");
    expect_fetch(32'h0000_2050, 8'hb4, "hit with not-taken prediction"); // one 0 shifted in
    report_test("install without mispredict");

    start_test();
    retire_strobe(1'b1, 32'h0000_8010, 32'h0000_9010, 8'hc3, 1'b1, 32'h0000_4400);
    expect_fetch(32'h0000_4400, 8'hc3, "mispredict redirect");
    expect_fetch(32'h0000_4410, 8'hc3, "sequential after redirect");
    report_test("mispredict redirect");

    // same bundle and history every time, so all three tables hit one entry each
    start_test();
    parity = 1'b0;
    for (int n = 0; n < 256; n++) begin
      parity ^= (mispred_count[1:0] == 2'b11) ^ (mispred_count[3:0] == 4'hf)
              ^ (mispred_count == 8'hff);
      mispredict_step(1'b0, 32'h0000_5060, 32'h0000_6000, 8'h2d,
                      parity ? 32'h0000_6000 : 32'h0000_5070, {7'h2d, parity});
    end
    report_test("throttled table toggles");

    // counter sits at 2 here
    start_test();
    retire_strobe(1'b0, 32'h0000_7080, 32'h0000_7400, 8'h00, 1'b0, 32'h0);
    retire_strobe(1'b1, 32'h0000_7080, 32'h0000_7800, 8'h00, 1'b0, 32'h0);
    mispredict_step(1'b1, 32'h0000_7080, 32'h0000_7800, 8'h81, 32'h0000_7090, 8'h04);
    mispredict_step(1'b1, 32'h0000_7080, 32'h0000_7800, 8'h81, 32'h0000_7800, 8'h05);
    for (int n = 0; n < 3; n++) begin
      mispredict_step(1'b0, 32'h0000_7080, 32'h0000_7400, 8'h81, 32'h0000_7800, 8'h05);
    end
    mispredict_step(1'b0, 32'h0000_7080, 32'h0000_7400, 8'h81, 32'h0000_7400, 8'h03);
    report_test("two-slot priority");

    start_test();
    random_retire_traffic(300);
    repeat (4) @(posedge clk);
    report_test("random retire traffic");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: tests did not finish within %0d clock cycles", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
rtl/frontend_pkg.sv
rtl/fetch_sequencer.sv
rtl/branch_target_buffer.sv
rtl/direction_predictor.sv
rtl/frontend.sv
testbench/tb_frontend.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - rtl/frontend_pkg.sv
  - rtl/fetch_sequencer.sv
  - rtl/branch_target_buffer.sv
  - rtl/direction_predictor.sv
  - rtl/frontend.sv
  - target: test
    files:
      - testbench/tb_frontend.sv
